// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/100ps -j 0
TOP      = tb_video_timing
FILELIST = vlog.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(TOOL), run $(TOP), check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "test passed" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/tb_video_timing.sv ====
`timescale 1ns/100ps

module tb_video_timing;

	localparam int DEBOUNCE   = 64;
	localparam int FMT_WAIT   = 400;      // Sync flops plus debounce and margin
	localparam int LINE_WAIT  = 4000;     // Longer than any line
	localparam int FRAME_WAIT = 1500000;  // Longer than a VGA or SVGA frame

	logic                        clk50m_bufg;
	logic                        RSTBTN;
	video_timing_pkg::fmt_code_t sw;
	logic                        hsync;
	logic                        vsync;
	logic                        de;
	video_timing_pkg::fmt_code_t fmt;

	int errors;
	int timeouts;

	// Format table copy in the order VGA SVGA XGA SXGA camera 720p
	int   h_pix_tab [6] = '{640, 800, 1024, 1280, 1280, 1280};
	int   h_fp_tab  [6] = '{16, 40, 24, 48, 110, 110};
	int   h_sw_tab  [6] = '{96, 128, 136, 112, 39, 40};
	int   h_bp_tab  [6] = '{48, 88, 160, 248, 220, 220};
	int   v_lin_tab [6] = '{480, 600, 768, 1024, 720, 720};
	int   v_fp_tab  [6] = '{11, 1, 3, 1, 4, 5};
	int   v_sw_tab  [6] = '{2, 4, 6, 3, 4, 5};
	int   v_bp_tab  [6] = '{31, 23, 29, 38, 22, 20};
	logic neg_tab   [6] = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};

	// Expected timing of the current format
	int   exp_line;   // Cycles per line
	int   exp_hsw;    // Hsync width in cycles
	int   exp_pix;
	int   exp_lines;  // Lines per frame
	int   exp_vsw;    // Vsync width in lines
	logic exp_neg;    // Also the idle level

	video_timing_top #(
		.DEBOUNCE_CYCLES(DEBOUNCE)
	) i_dut (
		.clk50m_bufg(clk50m_bufg),
		.RSTBTN     (RSTBTN),
		.sw         (sw),
		.hsync      (hsync),
		.vsync      (vsync),
		.de         (de),
		.fmt        (fmt)
	);

	initial begin
		clk50m_bufg = 1'b0;
		forever #10 clk50m_bufg = ~clk50m_bufg;  // 50 MHz
	end

	////////////////////
	// Helpers
	////////////////////
	function automatic int fmt_index(input logic [3:0] code);
		case (code)
			video_timing_pkg::FMT_VGA:    return 0;
			video_timing_pkg::FMT_SVGA:   return 1;
			video_timing_pkg::FMT_XGA:    return 2;
			video_timing_pkg::FMT_SXGA:   return 3;
			video_timing_pkg::FMT_CAMERA: return 4;
			default:                      return 5;  // 720p and unlisted codes
		endcase
	endfunction

	// Boundaries as last pixel of each region
	task automatic load_expect(input logic [3:0] code);
		int i;
		int hsblnk;
		int hssync;
		int hesync;
		int heblnk;
		int vsblnk;
		int vssync;
		int vesync;
		int veblnk;
		i = fmt_index(code);
		hsblnk = h_pix_tab[i] - 1;
		hssync = hsblnk + h_fp_tab[i];
		hesync = hssync + h_sw_tab[i];
		heblnk = hesync + h_bp_tab[i];
		vsblnk = v_lin_tab[i] - 1;
		vssync = vsblnk + v_fp_tab[i];
		vesync = vssync + v_sw_tab[i];
		veblnk = vesync + v_bp_tab[i];
		exp_line  = heblnk + 1;
		exp_hsw   = hesync - hssync;
		exp_pix   = h_pix_tab[i];
		exp_lines = veblnk + 1;
		exp_vsw   = vesync - vssync;
		exp_neg   = neg_tab[i];
	endtask

	// Sample and drive point 2 ns after the edge
	task automatic step;
		@(posedge clk50m_bufg);
		#2;
	endtask

	task automatic switch_format(input logic [3:0] code);
		int n;
		sw = code;
		n = 0;
		while (fmt != code && n < FMT_WAIT) begin
			step();
			n++;
		end
		if (fmt != code) begin
			$display("Timeout, fmt never changed to %h", code);
			timeouts++;
		end
		repeat (8) step();  // Let restart run through the pipe
		load_expect(code);
	endtask

	// Idle to active transition of hsync or vsync
	task automatic wait_edge(input bit vert, input int limit, output bit found);
		logic prev;
		logic cur;
		int   n;
		found = 1'b0;
		n = 0;
		prev = vert ? vsync : hsync;
		while (!found && n < limit) begin
			step();
			n++;
			cur   = vert ? vsync : hsync;
			found = (prev == exp_neg) && (cur != exp_neg);
			prev  = cur;
		end
		if (!found) begin
			$display("Timeout, no active %s edge seen", vert ? "vsync" : "hsync");
			timeouts++;
		end
	endtask

	// One line from hsync edge to hsync edge with an optional switch glitch
	task automatic measure_line(input bit glitch, input logic [3:0] glitch_code,
		output int period, output int hs_width, output int de_width);
		bit          found;
		bit          done;
		logic        prev;
		logic [3:0]  saved;
		period   = 0;
		hs_width = 0;
		de_width = 0;
		saved    = sw;
		wait_edge(1'b0, LINE_WAIT, found);
		if (found) begin
			prev     = hsync;
			hs_width = 1;     // Edge cycle is active
			done     = 1'b0;
			while (!done && period < LINE_WAIT) begin
				step();
				period++;
				if (glitch && period == 100) begin
					sw = glitch_code;
				end
				if (glitch && period == 130) begin
					sw = saved;  // 30 cycles is under the debounce time
				end
				done = (prev == exp_neg) && (hsync != exp_neg);
				if (!done && hsync != exp_neg) begin
					hs_width++;
				end
				if (!done && de) begin
					de_width++;
				end
				prev = hsync;
			end
			if (!done) begin
				$display("Timeout, hsync line did not end");
				timeouts++;
			end
		end
	endtask

	////////////////////
	// Directed tests
	////////////////////
	task automatic check_reset;
		if (fmt !== video_timing_pkg::FMT_VGA) begin
			$display("FAIL fmt expected %h actual %h", video_timing_pkg::FMT_VGA, fmt);
			errors++;
		end
		if (de !== 1'b0) begin
			$display("FAIL de expected %h actual %h", 1'b0, de);
			errors++;
		end
		if (hsync !== 1'b1) begin
			$display("FAIL hsync expected %h actual %h", 1'b1, hsync);
			errors++;
		end
		if (vsync !== 1'b1) begin
			$display("FAIL vsync expected %h actual %h", 1'b1, vsync);
			errors++;
		end
	endtask

	task automatic check_line(input logic [3:0] code);
		int period;
		int hs_width;
		int de_width;
		if (fmt == code) begin
			switch_format(code ^ 4'b0001);  // Force a restart so the line is live
		end
		switch_format(code);
		measure_line(1'b0, code, period, hs_width, de_width);
		if (period != exp_line) begin
			$display("FAIL hsync period expected %h actual %h", exp_line, period);
			errors++;
		end
		if (hs_width != exp_hsw) begin
			$display("FAIL hsync width expected %h actual %h", exp_hsw, hs_width);
			errors++;
		end
		if (de_width != exp_pix) begin
			$display("FAIL de width expected %h actual %h", exp_pix, de_width);
			errors++;
		end
	endtask

	task automatic check_frame(input logic [3:0] code);
		bit   found;
		bit   done;
		logic prev_h;
		logic prev_v;
		int   n;
		int   lines;
		int   vs_cycles;
		switch_format(code);
		wait_edge(1'b1, FRAME_WAIT, found);
		if (found) begin
			prev_h    = hsync;
			prev_v    = vsync;
			n         = 0;
			lines     = 0;
			vs_cycles = 1;
			done      = 1'b0;
			while (!done && n < FRAME_WAIT) begin
				step();
				n++;
				if (prev_h == exp_neg && hsync != exp_neg) begin
					lines++;  // One hsync edge per line
				end
				done = (prev_v == exp_neg) && (vsync != exp_neg);
				if (!done && vsync != exp_neg) begin
					vs_cycles++;
				end
				prev_h = hsync;
				prev_v = vsync;
			end
			if (!done) begin
				$display("Timeout, vsync frame did not end");
				timeouts++;
			end
			if (lines != exp_lines) begin
				$display("FAIL vsync frame lines expected %h actual %h", exp_lines, lines);
				errors++;
			end
			if (vs_cycles != exp_vsw * exp_line) begin
				$display("FAIL vsync width expected %h actual %h",
					exp_vsw * exp_line, vs_cycles);
				errors++;
			end
		end
	endtask

	task automatic check_polarity(input logic [3:0] code);
		int n;
		check_line(code);
		n = 0;
		while (!de && n < LINE_WAIT) begin
			step();
			n++;
		end
		if (!de) begin
			$display("Timeout, de never went high");
			timeouts++;
		end else begin
			// Both syncs sit idle during live pixels
			if (hsync !== exp_neg) begin
				$display("FAIL hsync idle expected %h actual %h", exp_neg, hsync);
				errors++;
			end
			if (vsync !== exp_neg) begin
				$display("FAIL vsync idle expected %h actual %h", exp_neg, vsync);
				errors++;
			end
		end
	endtask

	task automatic check_debounce;
		int period;
		int hs_width;
		int de_width;
		int n;
		load_expect(video_timing_pkg::FMT_VGA);
		measure_line(1'b1, video_timing_pkg::FMT_SVGA, period, hs_width, de_width);
		if (period != exp_line) begin
			$display("FAIL hsync period expected %h actual %h", exp_line, period);
			errors++;
		end
		repeat (100) step();
		if (fmt !== video_timing_pkg::FMT_VGA) begin
			$display("FAIL fmt expected %h actual %h", video_timing_pkg::FMT_VGA, fmt);
			errors++;
		end
		// Held code
		sw = video_timing_pkg::FMT_SVGA;
		n = 0;
		while (fmt == video_timing_pkg::FMT_VGA && n < FMT_WAIT) begin
			step();
			n++;
		end
		if (fmt !== video_timing_pkg::FMT_SVGA) begin
			$display("FAIL fmt expected %h actual %h", video_timing_pkg::FMT_SVGA, fmt);
			errors++;
		end else if (n < DEBOUNCE) begin
			$display("Switch code accepted after %0d cycles, before the debounce time", n);
			errors++;
		end
	endtask

	////////////////////
	// Main sequence
	////////////////////
	initial begin
		logic [3:0] codes [7];
		logic [3:0] tmp;
		int         j;
		void'($urandom(32'h463b));
		errors   = 0;
		timeouts = 0;
		RSTBTN   = 1'b1;
		sw       = video_timing_pkg::FMT_VGA;
		load_expect(video_timing_pkg::FMT_VGA);
		repeat (8) step();
		RSTBTN = 1'b0;
		check_reset();

		check_line(video_timing_pkg::FMT_VGA);
		check_debounce();  // Leaves SVGA accepted
		check_frame(video_timing_pkg::FMT_SVGA);
		check_frame(video_timing_pkg::FMT_VGA);
		check_polarity(video_timing_pkg::FMT_XGA);
		check_polarity(video_timing_pkg::FMT_SXGA);

		codes = '{video_timing_pkg::FMT_VGA, video_timing_pkg::FMT_SVGA,
			video_timing_pkg::FMT_HD720, video_timing_pkg::FMT_XGA,
			video_timing_pkg::FMT_SXGA, video_timing_pkg::FMT_CAMERA, 4'b0111};
		for (int i = 6; i > 0; i--) begin
			j        = int'($urandom % (i + 1));  // Shuffle
			tmp      = codes[i];
			codes[i] = codes[j];
			codes[j] = tmp;
		end
		for (int i = 0; i < 7; i++) begin
			check_line(codes[i]);
		end

		$display("errors %0d, timeouts %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// ==== verilog/format_decode.sv ====
`timescale 1ns/100ps

module format_decode #(
	parameter int DEBOUNCE_CYCLES = 50000  // Hold time for a new code
) (
	input  logic                        clk50m_bufg,
	input  logic                        RSTBTN,
	input  video_timing_pkg::fmt_code_t sw,        // Raw switches, async
	output logic                        restart,   // Raster restart pulse
	output video_timing_pkg::coord_t    hsblnk,
	output video_timing_pkg::coord_t    hssync,
	output video_timing_pkg::coord_t    hesync,
	output video_timing_pkg::coord_t    heblnk,
	output video_timing_pkg::coord_t    vsblnk,
	output video_timing_pkg::coord_t    vssync,
	output video_timing_pkg::coord_t    vesync,
	output video_timing_pkg::coord_t    veblnk,
	output logic                        sync_neg,  // 1 = active low syncs
	output video_timing_pkg::fmt_code_t fmt        // Accepted code
);

	localparam int CNT_W = $clog2(DEBOUNCE_CYCLES);

	video_timing_pkg::fmt_code_t sw_meta;
	video_timing_pkg::fmt_code_t sw_sync;
	video_timing_pkg::fmt_code_t cand;      // Code being debounced
	video_timing_pkg::db_state_t state;
	logic [CNT_W-1:0]            settle_cnt;
	logic                        load;      // Accepted last cycle

	// Table lookup
	video_timing_pkg::fmt_code_t lut_code;
	video_timing_pkg::coord_t    h_pix;
	video_timing_pkg::coord_t    h_fp;
	video_timing_pkg::coord_t    h_sw;
	video_timing_pkg::coord_t    h_bp;
	video_timing_pkg::coord_t    v_lines;
	video_timing_pkg::coord_t    v_fp;
	video_timing_pkg::coord_t    v_sw;
	video_timing_pkg::coord_t    v_bp;
	logic                        lut_neg;

	// Two-flop synchroniser
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			sw_meta <= video_timing_pkg::FMT_VGA;
			sw_sync <= video_timing_pkg::FMT_VGA;
		end else begin
			sw_meta <= sw;
			sw_sync <= sw_meta;
		end
	end

	////////////////////
	// Debounce FSM
	////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			state      <= video_timing_pkg::DB_STABLE;
			cand       <= video_timing_pkg::FMT_VGA;
			settle_cnt <= '0;
			fmt        <= video_timing_pkg::FMT_VGA;  // Power up in VGA
			load       <= 1'b0;
		end else begin
			load <= 1'b0;
			case (state)
				video_timing_pkg::DB_STABLE: begin
					if (sw_sync != fmt) begin  // New code seen
						cand       <= sw_sync;
						settle_cnt <= '0;
						state      <= video_timing_pkg::DB_SETTLE;
					end
				end
				video_timing_pkg::DB_SETTLE: begin
					if (sw_sync == fmt) begin
						// Glitch, back to the accepted code, raster untouched
						state <= video_timing_pkg::DB_STABLE;
					end else if (sw_sync != cand) begin
						cand       <= sw_sync;  // Still bouncing, count again
						settle_cnt <= '0;
					end else if (settle_cnt == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
						fmt   <= cand;          // Accept
						load  <= 1'b1;
						state <= video_timing_pkg::DB_STABLE;
					end else begin
						settle_cnt <= settle_cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// VGA during reset so boundaries come up valid
	assign lut_code = RSTBTN ? video_timing_pkg::FMT_VGA : fmt;

	////////////////////
	// Format table
	////////////////////
	always_comb begin
		// 720p unless a listed code
		h_pix   = video_timing_pkg::HD720_H_PIX;
		h_fp    = video_timing_pkg::HD720_H_FP;
		h_sw    = video_timing_pkg::HD720_H_SW;
		h_bp    = video_timing_pkg::HD720_H_BP;
		v_lines = video_timing_pkg::HD720_V_LINES;
		v_fp    = video_timing_pkg::HD720_V_FP;
		v_sw    = video_timing_pkg::HD720_V_SW;
		v_bp    = video_timing_pkg::HD720_V_BP;
		lut_neg = video_timing_pkg::HD720_NEG;
		case (lut_code)
			video_timing_pkg::FMT_VGA: begin
				h_pix   = video_timing_pkg::VGA_H_PIX;
				h_fp    = video_timing_pkg::VGA_H_FP;
				h_sw    = video_timing_pkg::VGA_H_SW;
				h_bp    = video_timing_pkg::VGA_H_BP;
				v_lines = video_timing_pkg::VGA_V_LINES;
				v_fp    = video_timing_pkg::VGA_V_FP;
				v_sw    = video_timing_pkg::VGA_V_SW;
				v_bp    = video_timing_pkg::VGA_V_BP;
				lut_neg = video_timing_pkg::VGA_NEG;
			end
			video_timing_pkg::FMT_SVGA: begin
				h_pix   = video_timing_pkg::SVGA_H_PIX;
				h_fp    = video_timing_pkg::SVGA_H_FP;
				h_sw    = video_timing_pkg::SVGA_H_SW;
				h_bp    = video_timing_pkg::SVGA_H_BP;
				v_lines = video_timing_pkg::SVGA_V_LINES;
				v_fp    = video_timing_pkg::SVGA_V_FP;
				v_sw    = video_timing_pkg::SVGA_V_SW;
				v_bp    = video_timing_pkg::SVGA_V_BP;
				lut_neg = video_timing_pkg::SVGA_NEG;
			end
			video_timing_pkg::FMT_XGA: begin
				h_pix   = video_timing_pkg::XGA_H_PIX;
				h_fp    = video_timing_pkg::XGA_H_FP;
				h_sw    = video_timing_pkg::XGA_H_SW;
				h_bp    = video_timing_pkg::XGA_H_BP;
				v_lines = video_timing_pkg::XGA_V_LINES;
				v_fp    = video_timing_pkg::XGA_V_FP;
				v_sw    = video_timing_pkg::XGA_V_SW;
				v_bp    = video_timing_pkg::XGA_V_BP;
				lut_neg = video_timing_pkg::XGA_NEG;
			end
			video_timing_pkg::FMT_SXGA: begin
				h_pix   = video_timing_pkg::SXGA_H_PIX;
				h_fp    = video_timing_pkg::SXGA_H_FP;
				h_sw    = video_timing_pkg::SXGA_H_SW;
				h_bp    = video_timing_pkg::SXGA_H_BP;
				v_lines = video_timing_pkg::SXGA_V_LINES;
				v_fp    = video_timing_pkg::SXGA_V_FP;
				v_sw    = video_timing_pkg::SXGA_V_SW;
				v_bp    = video_timing_pkg::SXGA_V_BP;
				lut_neg = video_timing_pkg::SXGA_NEG;
			end
			video_timing_pkg::FMT_CAMERA: begin
				h_pix   = video_timing_pkg::CAM_H_PIX;
				h_fp    = video_timing_pkg::CAM_H_FP;
				h_sw    = video_timing_pkg::CAM_H_SW;
				h_bp    = video_timing_pkg::CAM_H_BP;
				v_lines = video_timing_pkg::CAM_V_LINES;
				v_fp    = video_timing_pkg::CAM_V_FP;
				v_sw    = video_timing_pkg::CAM_V_SW;
				v_bp    = video_timing_pkg::CAM_V_BP;
				lut_neg = video_timing_pkg::CAM_NEG;
			end
			video_timing_pkg::FMT_HD720: ;  // Values set above
			default: ;                      // Unlisted codes fall back to 720p
		endcase
	end

	// Restart marks the cycle new boundaries are valid
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			restart <= 1'b1;  // Seen on first cycle out of reset
		end else begin
			restart <= load;
		end
	end

	// Boundary registers, last pixel of each region
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN || load) begin
			hsblnk   <= h_pix - 11'd1;
			hssync   <= h_pix - 11'd1 + h_fp;
			hesync   <= h_pix - 11'd1 + h_fp + h_sw;
			heblnk   <= h_pix - 11'd1 + h_fp + h_sw + h_bp;
			vsblnk   <= v_lines - 11'd1;
			vssync   <= v_lines - 11'd1 + v_fp;
			vesync   <= v_lines - 11'd1 + v_fp + v_sw;
			veblnk   <= v_lines - 11'd1 + v_fp + v_sw + v_bp;
			sync_neg <= lut_neg;
		end
	end

endmodule

// ==== verilog/raster_counter.sv ====
`timescale 1ns/100ps

module raster_counter (
	input  logic                     clk50m_bufg,
	input  logic                     RSTBTN,
	input  logic                     restart,    // Zero both counters
	input  video_timing_pkg::coord_t hsblnk,     // Last live pixel
	input  video_timing_pkg::coord_t hssync,     // Last front porch pixel
	input  video_timing_pkg::coord_t hesync,     // Last sync pixel
	input  video_timing_pkg::coord_t heblnk,     // Last pixel of the line
	input  video_timing_pkg::coord_t vsblnk,
	input  video_timing_pkg::coord_t vssync,
	input  video_timing_pkg::coord_t vesync,
	input  video_timing_pkg::coord_t veblnk,
	output logic                     hsync_raw,  // Active high, no polarity
	output logic                     vsync_raw,
	output logic                     hblnk,
	output logic                     vblnk
);

	video_timing_pkg::coord_t hcount;
	video_timing_pkg::coord_t vcount;
	logic                     line_end;   // Last pixel of line
	logic                     frame_end;  // Last line of frame

	// Compare with >= so a shorter new format cannot run away
	assign line_end  = (hcount >= heblnk);
	assign frame_end = (vcount >= veblnk);

	////////////////////
	// Position counters
	////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			hcount <= '0;
			vcount <= '0;
		end else if (restart) begin
			hcount <= '0;  // New format, start at top left
			vcount <= '0;
		end else begin
			if (line_end) begin
				hcount <= '0;
				if (frame_end) begin
					vcount <= '0;
				end else begin
					vcount <= vcount + 11'd1;  // Next line
				end
			end else begin
				hcount <= hcount + 11'd1;
			end
		end
	end

	////////////////////
	// Raw flags
	////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			hsync_raw <= 1'b0;
			vsync_raw <= 1'b0;
			hblnk     <= 1'b0;
			vblnk     <= 1'b0;
		end else begin
			hblnk     <= (hcount > hsblnk);
			hsync_raw <= (hcount > hssync) && (hcount <= hesync);
			vblnk     <= (vcount > vsblnk);  // Whole line blanked
			vsync_raw <= (vcount > vssync) && (vcount <= vesync);
		end
	end

endmodule

// ==== verilog/sync_output.sv ====
`timescale 1ns/100ps

module sync_output (
	input  logic clk50m_bufg,
	input  logic RSTBTN,
	input  logic sync_neg,   // 1 = active low syncs
	input  logic hsync_raw,
	input  logic vsync_raw,
	input  logic hblnk,
	input  logic vblnk,
	output logic hsync,
	output logic vsync,
	output logic de          // Live pixel
);

	logic hs_q;
	logic vs_q;
	logic act_q;

	////////////////////
	// Two-stage pipe
	////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			// Idle level of the current polarity
			hs_q  <= sync_neg;
			vs_q  <= sync_neg;
			act_q <= 1'b0;
			hsync <= sync_neg;
			vsync <= sync_neg;
			de    <= 1'b0;
		end else begin
			hs_q  <= hsync_raw ^ sync_neg;  // Polarity in stage 1
			vs_q  <= vsync_raw ^ sync_neg;
			act_q <= !hblnk && !vblnk;
			hsync <= hs_q;
			vsync <= vs_q;
			de    <= act_q;
		end
	end

endmodule

// ==== verilog/video_timing_pkg.sv ====
package video_timing_pkg;

	typedef logic [10:0] coord_t;     // Raster position or boundary
	typedef logic [3:0]  fmt_code_t;  // Switch code

	// Debouncer states
	typedef enum logic {
		DB_STABLE,  // Accepted code matches switches
		DB_SETTLE   // New code waiting out the bounce
	} db_state_t;

	////////////////////
	// Switch codes
	////////////////////
	localparam fmt_code_t FMT_VGA    = 4'b0000;
	localparam fmt_code_t FMT_SVGA   = 4'b0001;
	localparam fmt_code_t FMT_HD720  = 4'b0010;  // Also any unlisted code
	localparam fmt_code_t FMT_XGA    = 4'b0011;
	localparam fmt_code_t FMT_SXGA   = 4'b1000;
	localparam fmt_code_t FMT_CAMERA = 4'b1001;

	////////////////////
	// Format table
	////////////////////
	// 640x480
	localparam coord_t VGA_H_PIX   = 11'd640;
	localparam coord_t VGA_H_FP    = 11'd16;
	localparam coord_t VGA_H_SW    = 11'd96;
	localparam coord_t VGA_H_BP    = 11'd48;
	localparam coord_t VGA_V_LINES = 11'd480;
	localparam coord_t VGA_V_FP    = 11'd11;
	localparam coord_t VGA_V_SW    = 11'd2;
	localparam coord_t VGA_V_BP    = 11'd31;
	localparam logic   VGA_NEG     = 1'b1;  // Negative sync

	// 800x600
	localparam coord_t SVGA_H_PIX   = 11'd800;
	localparam coord_t SVGA_H_FP    = 11'd40;
	localparam coord_t SVGA_H_SW    = 11'd128;
	localparam coord_t SVGA_H_BP    = 11'd88;
	localparam coord_t SVGA_V_LINES = 11'd600;
	localparam coord_t SVGA_V_FP    = 11'd1;
	localparam coord_t SVGA_V_SW    = 11'd4;
	localparam coord_t SVGA_V_BP    = 11'd23;
	localparam logic   SVGA_NEG     = 1'b0;

	// 1024x768
	localparam coord_t XGA_H_PIX   = 11'd1024;
	localparam coord_t XGA_H_FP    = 11'd24;
	localparam coord_t XGA_H_SW    = 11'd136;
	localparam coord_t XGA_H_BP    = 11'd160;
	localparam coord_t XGA_V_LINES = 11'd768;
	localparam coord_t XGA_V_FP    = 11'd3;
	localparam coord_t XGA_V_SW    = 11'd6;
	localparam coord_t XGA_V_BP    = 11'd29;
	localparam logic   XGA_NEG     = 1'b1;  // Negative sync

	// 1280x1024
	localparam coord_t SXGA_H_PIX   = 11'd1280;
	localparam coord_t SXGA_H_FP    = 11'd48;
	localparam coord_t SXGA_H_SW    = 11'd112;
	localparam coord_t SXGA_H_BP    = 11'd248;
	localparam coord_t SXGA_V_LINES = 11'd1024;
	localparam coord_t SXGA_V_FP    = 11'd1;
	localparam coord_t SXGA_V_SW    = 11'd3;
	localparam coord_t SXGA_V_BP    = 11'd38;
	localparam logic   SXGA_NEG     = 1'b0;

	// Camera 1280x720, one pixel shorter hsync than 720p
	localparam coord_t CAM_H_PIX   = 11'd1280;
	localparam coord_t CAM_H_FP    = 11'd110;
	localparam coord_t CAM_H_SW    = 11'd39;
	localparam coord_t CAM_H_BP    = 11'd220;
	localparam coord_t CAM_V_LINES = 11'd720;
	localparam coord_t CAM_V_FP    = 11'd4;
	localparam coord_t CAM_V_SW    = 11'd4;
	localparam coord_t CAM_V_BP    = 11'd22;
	localparam logic   CAM_NEG     = 1'b0;

	// 720p, the fallback format
	localparam coord_t HD720_H_PIX   = 11'd1280;
	localparam coord_t HD720_H_FP    = 11'd110;
	localparam coord_t HD720_H_SW    = 11'd40;
	localparam coord_t HD720_H_BP    = 11'd220;
	localparam coord_t HD720_V_LINES = 11'd720;
	localparam coord_t HD720_V_FP    = 11'd5;
	localparam coord_t HD720_V_SW    = 11'd5;
	localparam coord_t HD720_V_BP    = 11'd20;
	localparam logic   HD720_NEG     = 1'b0;

endpackage

// ==== verilog/video_timing_top.sv ====
`timescale 1ns/100ps

module video_timing_top #(
	parameter int DEBOUNCE_CYCLES = 50000  // 1 ms at 50 MHz
) (
	input  logic                        clk50m_bufg,
	input  logic                        RSTBTN,
	input  video_timing_pkg::fmt_code_t sw,
	output logic                        hsync,
	output logic                        vsync,
	output logic                        de,
	output video_timing_pkg::fmt_code_t fmt
);

	logic                     restart;
	logic                     sync_neg;
	video_timing_pkg::coord_t hsblnk;
	video_timing_pkg::coord_t hssync;
	video_timing_pkg::coord_t hesync;
	video_timing_pkg::coord_t heblnk;
	video_timing_pkg::coord_t vsblnk;
	video_timing_pkg::coord_t vssync;
	video_timing_pkg::coord_t vesync;
	video_timing_pkg::coord_t veblnk;
	logic                     hsync_raw;
	logic                     vsync_raw;
	logic                     hblnk;
	logic                     vblnk;

	////////////////////
	// Switch decode
	////////////////////
	format_decode #(
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
	) i_format_decode (
		.clk50m_bufg(clk50m_bufg),
		.RSTBTN     (RSTBTN),
		.sw         (sw),
		.restart    (restart),
		.hsblnk     (hsblnk),
		.hssync     (hssync),
		.hesync     (hesync),
		.heblnk     (heblnk),
		.vsblnk     (vsblnk),
		.vssync     (vssync),
		.vesync     (vesync),
		.veblnk     (veblnk),
		.sync_neg   (sync_neg),
		.fmt        (fmt)
	);

	// Raster position
	raster_counter i_raster_counter (
		.clk50m_bufg(clk50m_bufg),
		.RSTBTN     (RSTBTN),
		.restart    (restart),
		.hsblnk     (hsblnk),
		.hssync     (hssync),
		.hesync     (hesync),
		.heblnk     (heblnk),
		.vsblnk     (vsblnk),
		.vssync     (vssync),
		.vesync     (vesync),
		.veblnk     (veblnk),
		.hsync_raw  (hsync_raw),
		.vsync_raw  (vsync_raw),
		.hblnk      (hblnk),
		.vblnk      (vblnk)
	);

	// Polarity and output registers
	sync_output i_sync_output (
		.clk50m_bufg(clk50m_bufg),
		.RSTBTN     (RSTBTN),
		.sync_neg   (sync_neg),
		.hsync_raw  (hsync_raw),
		.vsync_raw  (vsync_raw),
		.hblnk      (hblnk),
		.vblnk      (vblnk),
		.hsync      (hsync),
		.vsync      (vsync),
		.de         (de)
	);

endmodule

// ==== vlog.f ====
verilog/video_timing_pkg.sv
verilog/format_decode.sv
verilog/raster_counter.sv
verilog/sync_output.sv
verilog/video_timing_top.sv
sim/tb_video_timing.sv
